//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module tb_cache \
		-Mdir obj_dir -o tb_cache -f files.f

run: compile
	./obj_dir/tb_cache | tee sim.log
	grep -q "^\*\* PASS \*\*$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- cache/cache_data_mem.sv
`default_nettype none

module cache_data_mem
    import cache_pkg::*;
(
    input  wire logic     clk_i,
    input  wire mem_ctl_t req_i,
    input  wire line_t    wdata_i,
    output line_t         rdata_o
);

    // one full line per set
    line_t line_mem [NUM_SETS];

    // read is combinational
    // same cycle as the index
    assign rdata_o = line_mem[req_i.index];

    // whole line written on enable
    // word merge is done by the controller
    always_ff @(posedge clk_i) begin
        if (req_i.we) begin
            line_mem[req_i.index] <= wdata_i;
        end
    end

endmodule

`default_nettype wire

//--- cache/cache_fsm.sv
`default_nettype none

module cache_fsm
    import cache_pkg::*;
(
    input  wire logic       clk_i,
    input  wire logic       rst_ni,
    input  wire cpu_req_t   cpu_req_i,
    input  wire mem_data_t  mem_data_i,
    input  wire tag_entry_t tag_rdata_i,
    input  wire line_t      data_rdata_i,
    output mem_ctl_t        tag_req_o,
    output tag_entry_t      tag_wdata_o,
    output mem_ctl_t        data_req_o,
    output line_t           data_wdata_o,
    output cpu_res_t        cpu_res_o,
    output mem_req_t        mem_req_o,
    output cache_evt_t      evt_o,
    output logic            busy_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_COMPARE,
        ST_ALLOCATE,
        ST_WRITE_BACK
    } state_e;

    state_e state_q;
    state_e state_d;

    // fields of the current cpu address
    index_t req_index;
    tag_t req_tag;
    logic [OFFSET_W-BYTE_OFF_W-1:0] word_sel;

    logic hit;
    logic victim_dirty;

    // old line address kept for the write-back cycle
    addr_t victim_addr_q;

    assign req_index = cpu_req_i.addr[OFFSET_W +: INDEX_W];
    assign req_tag = cpu_req_i.addr[ADDR_W-1 -: TAG_W];
    assign word_sel = cpu_req_i.addr[OFFSET_W-1:BYTE_OFF_W];

    // hit needs a valid entry with matching tag
    assign hit = tag_rdata_i.valid && (tag_rdata_i.tag == req_tag);
    assign victim_dirty = tag_rdata_i.valid && tag_rdata_i.dirty;

    always_comb begin
        // stay put unless told otherwise
        state_d = state_q;

        // both arrays indexed by the cpu address
        tag_req_o.index = req_index;
        tag_req_o.we = 1'b0;
        data_req_o.index = req_index;
        data_req_o.we = 1'b0;

        // default tag write keeps the stored entry
        tag_wdata_o = tag_rdata_i;

        // default line write merges the cpu word
        data_wdata_o = data_rdata_i;
        data_wdata_o[word_sel*WORD_W +: WORD_W] = cpu_req_i.data;

        // read word picked from the stored line
        cpu_res_o.data = data_rdata_i[word_sel*WORD_W +: WORD_W];
        cpu_res_o.ready = 1'b0;

        // line fill request for the cpu address
        mem_req_o.addr = {req_tag, req_index, {OFFSET_W{1'b0}}};
        mem_req_o.data = data_rdata_i;
        mem_req_o.rw = 1'b0;
        mem_req_o.valid = 1'b0;

        evt_o.access = 1'b0;
        evt_o.miss = 1'b0;
        busy_o = 1'b0;

        case (state_q)
            ST_IDLE: begin
                // new request is counted once here
                if (cpu_req_i.valid) begin
                    evt_o.access = 1'b1;
                    state_d = ST_COMPARE;
                end
            end

            ST_COMPARE: begin
                if (hit) begin
                    cpu_res_o.ready = 1'b1;
                    if (cpu_req_i.rw) begin
                        // write hit merges the word and marks the line dirty
                        data_req_o.we = 1'b1;
                        tag_req_o.we = 1'b1;
                        tag_wdata_o.valid = 1'b1;
                        tag_wdata_o.dirty = 1'b1;
                    end
                    state_d = ST_IDLE;
                end else begin
                    busy_o = 1'b1;
                    evt_o.miss = 1'b1;

                    // install new tag now
                    // the data array still holds the victim line
                    tag_req_o.we = 1'b1;
                    tag_wdata_o.tag = req_tag;
                    tag_wdata_o.valid = 1'b1;
                    tag_wdata_o.dirty = cpu_req_i.rw;

                    if (victim_dirty) begin
                        // victim goes out first
                        state_d = ST_WRITE_BACK;
                    end else begin
                        // clean or empty victim is simply replaced
                        mem_req_o.valid = 1'b1;
                        state_d = ST_ALLOCATE;
                    end
                end
            end

            ST_WRITE_BACK: begin
                busy_o = 1'b1;

                // single cycle write that memory takes now
                mem_req_o.addr = victim_addr_q;
                mem_req_o.rw = 1'b1;
                mem_req_o.valid = 1'b1;
                state_d = ST_ALLOCATE;
            end

            ST_ALLOCATE: begin
                busy_o = 1'b1;

                // read request held until memory answers
                mem_req_o.valid = 1'b1;
                if (mem_data_i.ready) begin
                    data_wdata_o = mem_data_i.data;
                    data_req_o.we = 1'b1;
                    // re-compare so a write miss merges its word
                    state_d = ST_COMPARE;
                end
            end

            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // victim address captured on the miss compare
    always_ff @(posedge clk_i) begin
        if (state_q == ST_COMPARE && !hit) begin
            victim_addr_q <= {tag_rdata_i.tag, req_index, {OFFSET_W{1'b0}}};
        end
    end

    // cpu ready never shares a cycle with a memory request
    // and follows a pending fill only once memory has answered it
    a_no_ready_with_mem: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        cpu_res_o.ready |-> !mem_req_o.valid
            && (!$past(mem_req_o.valid) || $past(mem_data_i.ready))
    );

    a_state_known: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        !$isunknown(state_q)
    );

endmodule

`default_nettype wire

//--- cache/cache_tag_mem.sv
`default_nettype none

module cache_tag_mem
    import cache_pkg::*;
(
    input  wire logic       clk_i,
    input  wire logic       rst_ni,
    input  wire mem_ctl_t   req_i,
    input  wire tag_entry_t wdata_i,
    output tag_entry_t      rdata_o
);

    // tag and dirty bits per set, no reset
    tag_t tag_mem [NUM_SETS];
    logic dirty_mem [NUM_SETS];

    // valid bits live apart so reset clears them all at once
    logic [NUM_SETS-1:0] valid_q;

    // combinational read at the request index
    assign rdata_o.tag = tag_mem[req_i.index];
    assign rdata_o.valid = valid_q[req_i.index];
    assign rdata_o.dirty = dirty_mem[req_i.index];

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (req_i.we) begin
            valid_q[req_i.index] <= wdata_i.valid;
        end
    end

    // payload write, only meaningful once valid is set
    always_ff @(posedge clk_i) begin
        if (req_i.we) begin
            tag_mem[req_i.index] <= wdata_i.tag;
            dirty_mem[req_i.index] <= wdata_i.dirty;
        end
    end

    // an unknown enable would corrupt valid state
    a_we_known: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        !$isunknown(req_i.we)
    );

endmodule

`default_nettype wire

//--- cache/cache_top.sv
`default_nettype none

module cache_top
    import cache_pkg::*;
#(
    parameter int unsigned CNT_W = 32
) (
    input  wire logic       clk_i,
    input  wire logic       rst_ni,
    input  wire cpu_req_t   cpu_req_i,
    output cpu_res_t        cpu_res_o,
    output mem_req_t        mem_req_o,
    input  wire mem_data_t  mem_data_i,
    output logic [CNT_W-1:0] acc_count_o,
    output logic [CNT_W-1:0] miss_count_o,
    output logic            busy_o
);

    // tag array side
    mem_ctl_t tag_req;
    tag_entry_t tag_wdata;
    tag_entry_t tag_rdata;

    // data array side
    mem_ctl_t data_req;
    line_t data_wdata;
    line_t data_rdata;

    // event pulses to the counters
    cache_evt_t evt;

    cache_fsm i_fsm (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .cpu_req_i    (cpu_req_i),
        .mem_data_i   (mem_data_i),
        .tag_rdata_i  (tag_rdata),
        .data_rdata_i (data_rdata),
        .tag_req_o    (tag_req),
        .tag_wdata_o  (tag_wdata),
        .data_req_o   (data_req),
        .data_wdata_o (data_wdata),
        .cpu_res_o    (cpu_res_o),
        .mem_req_o    (mem_req_o),
        .evt_o        (evt),
        .busy_o       (busy_o)
    );

    cache_tag_mem i_tag_mem (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .req_i   (tag_req),
        .wdata_i (tag_wdata),
        .rdata_o (tag_rdata)
    );

    // line storage has no reset
    cache_data_mem i_data_mem (
        .clk_i   (clk_i),
        .req_i   (data_req),
        .wdata_i (data_wdata),
        .rdata_o (data_rdata)
    );

    cache_perf_counters #(
        .CNT_W (CNT_W)
    ) i_perf (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .evt_i        (evt),
        .acc_count_o  (acc_count_o),
        .miss_count_o (miss_count_o)
    );

endmodule

`default_nettype wire

//--- common/cache_pkg.sv
`default_nettype none

package cache_pkg;

    // cache geometry
    // direct mapped, 16-byte lines, 1024 sets
    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;
    localparam int LINE_W = 128;
    localparam int OFFSET_W = 4;
    localparam int INDEX_W = 10;
    localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;

    // byte bits below the word select
    localparam int BYTE_OFF_W = $clog2(WORD_W / 8);
    localparam int NUM_SETS = 2 ** INDEX_W;

    // plain vectors with a meaning
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [LINE_W-1:0] line_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0] tag_t;

    // cpu side request, held until ready
    typedef struct packed {
        addr_t addr;
        word_t data;
        // 1 means write
        logic  rw;
        logic  valid;
    } cpu_req_t;

    // cpu side result, ready is a one-cycle pulse
    typedef struct packed {
        word_t data;
        logic  ready;
    } cpu_res_t;

    // memory request, addr is line aligned
    typedef struct packed {
        addr_t addr;
        line_t data;
        logic  rw;
        logic  valid;
    } mem_req_t;

    // memory reply for reads
    typedef struct packed {
        line_t data;
        logic  ready;
    } mem_data_t;

    // one stored tag entry per set
    typedef struct packed {
        tag_t tag;
        logic valid;
        logic dirty;
    } tag_entry_t;

    // index and write enable into tag or data array
    typedef struct packed {
        index_t index;
        logic   we;
    } mem_ctl_t;

    // controller event pulses for the counters
    typedef struct packed {
        logic access;
        logic miss;
    } cache_evt_t;

endpackage

`default_nettype wire

//--- files.f
common/cache_pkg.sv
cache/cache_tag_mem.sv
cache/cache_data_mem.sv
logic/cache_perf_counters.sv
cache/cache_fsm.sv
cache/cache_top.sv
tests/mem_model.sv
tests/tb_cache.sv

//--- logic/cache_perf_counters.sv
`default_nettype none

module cache_perf_counters
    import cache_pkg::*;
#(
    parameter int unsigned CNT_W = 32
) (
    input  wire logic       clk_i,
    input  wire logic       rst_ni,
    input  wire cache_evt_t evt_i,
    output logic [CNT_W-1:0] acc_count_o,
    output logic [CNT_W-1:0] miss_count_o
);

    logic [CNT_W-1:0] acc_q;
    logic [CNT_W-1:0] miss_q;

    // both counters stick at all ones
    // hits are accesses minus misses, outside
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            acc_q <= '0;
            miss_q <= '0;
        end else begin
            if (evt_i.access && (acc_q != '1)) begin
                acc_q <= acc_q + CNT_W'(1);
            end
            if (evt_i.miss && (miss_q != '1)) begin
                miss_q <= miss_q + CNT_W'(1);
            end
        end
    end

    assign acc_count_o = acc_q;
    assign miss_count_o = miss_q;

    // a miss is only ever flagged on a counted access
    a_miss_le_acc: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        miss_q <= acc_q
    );

endmodule

`default_nettype wire

//--- tests/mem_model.sv
`default_nettype none

module mem_model
    import cache_pkg::*;
(
    input  wire logic     clk_i,
    input  wire logic     rst_ni,
    input  wire mem_req_t mem_req_i,
    output mem_data_t     mem_data_o
);

    // written-back lines, keyed by line address
    line_t store [addr_t];

    int latency;
    addr_t fill_addr;

    // initial contents, every address bit mixed in
    function automatic word_t fill_word(input addr_t addr);
        return (addr * 32'h9E37_79B1) ^ 32'h5A5A_A5A5;
    endfunction

    // stored line if written back, else the fill pattern
    function automatic line_t read_line(input addr_t line_addr);
        line_t line;
        if (store.exists(line_addr)) begin
            line = store[line_addr];
        end else begin
            for (int w = 0; w < LINE_W / WORD_W; w++) begin
                line[w*WORD_W +: WORD_W] = fill_word(line_addr + addr_t'(4 * w));
            end
        end
        return line;
    endfunction

    initial begin
        mem_data_o = '0;
        forever begin
            // request is stable mid-cycle
            @(negedge clk_i);
            if (rst_ni && mem_req_i.valid && mem_req_i.rw) begin
                // write-back is shown for one cycle only
                store[mem_req_i.addr] = mem_req_i.data;
            end else if (rst_ni && mem_req_i.valid) begin
                fill_addr = mem_req_i.addr;
                // 1 to 6 cycles until the line comes back
                latency = 1 + int'($urandom_range(5, 0));
                repeat (latency) @(posedge clk_i);
                #1;
                mem_data_o.data = read_line(fill_addr);
                mem_data_o.ready = 1'b1;
                @(posedge clk_i);
                #1;
                mem_data_o.ready = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- tests/tb_cache.sv
`default_nettype none

module tb_cache
    import cache_pkg::*;
();

    localparam int CNT_W = 32;
    localparam int NUM_RANDOM = 400;
    localparam int NUM_DIRECTED = 16;
    // worst request is a dirty miss at the longest memory latency, well under this
    localparam int CYCLES_PER_REQ = 20;
    localparam int TIMEOUT_CYCLES = (NUM_RANDOM + NUM_DIRECTED) * CYCLES_PER_REQ + 16;

    // what one cpu request should return
    typedef struct packed {
        addr_t line_addr;
        word_t rdata;
        logic  rw;
        logic  hit;
    } expect_t;

    // one expected write-back cycle
    typedef struct packed {
        addr_t addr;
        line_t data;
    } wb_expect_t;

    logic clk;
    logic rst_n;
    cpu_req_t cpu_req;
    cpu_res_t cpu_res;
    mem_req_t mem_req;
    mem_data_t mem_data;
    logic [CNT_W-1:0] acc_count;
    logic [CNT_W-1:0] miss_count;
    logic busy;

    // shadow memory holds the latest value of every byte
    logic [7:0] shadow_mem [addr_t];
    tag_t ref_tag [NUM_SETS];
    logic ref_valid [NUM_SETS];
    logic ref_dirty [NUM_SETS];
    int ref_misses = 0;

    expect_t exp_q [$];
    wb_expect_t wb_q [$];
    string test_name = "reset";
    logic saw_fill = 1'b0;
    int req_count = 0;
    int cycles = 0;

    cache_top #(
        .CNT_W (CNT_W)
    ) i_dut (
        .clk_i        (clk),
        .rst_ni       (rst_n),
        .cpu_req_i    (cpu_req),
        .cpu_res_o    (cpu_res),
        .mem_req_o    (mem_req),
        .mem_data_i   (mem_data),
        .acc_count_o  (acc_count),
        .miss_count_o (miss_count),
        .busy_o       (busy)
    );

    mem_model i_mem (
        .clk_i      (clk),
        .rst_ni     (rst_n),
        .mem_req_i  (mem_req),
        .mem_data_o (mem_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: no cpu response after %0d cycles, the run hung", cycles);
            $display("** FAIL **");
            $fatal(1, "simulation timed out");
        end
    end

    task automatic check_value(input string name, input line_t expected, input line_t actual);
        if (expected !== actual) begin
            $display("** Error: %s expected %h actual %h", name, expected, actual);
            $display("** FAIL **");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // backing memory contents before any write-back
    function automatic word_t fill_word(input addr_t addr);
        return (addr * 32'h9E37_79B1) ^ 32'h5A5A_A5A5;
    endfunction

    function automatic logic [7:0] shadow_byte(input addr_t addr);
        word_t w;
        if (shadow_mem.exists(addr)) begin
            return shadow_mem[addr];
        end
        w = fill_word({addr[ADDR_W-1:2], 2'b00});
        return w[8*addr[1:0] +: 8];
    endfunction

    function automatic word_t shadow_word(input addr_t addr);
        word_t w;
        for (int b = 0; b < 4; b++) begin
            w[8*b +: 8] = shadow_byte(addr + addr_t'(b));
        end
        return w;
    endfunction

    function automatic line_t shadow_line(input addr_t line_addr);
        line_t l;
        for (int b = 0; b < LINE_W / 8; b++) begin
            l[8*b +: 8] = shadow_byte(line_addr + addr_t'(b));
        end
        return l;
    endfunction

    // reference model, direct mapped write-back write-allocate
    function automatic void ref_access(input addr_t addr, input word_t wdata, input logic rw,
                                       output expect_t exp, output logic wb,
                                       output wb_expect_t wb_exp);
        index_t idx;
        tag_t tag;
        addr_t word_addr;
        idx = addr[OFFSET_W +: INDEX_W];
        tag = addr[ADDR_W-1 -: TAG_W];
        word_addr = {addr[ADDR_W-1:2], 2'b00};
        exp.line_addr = {tag, idx, 4'b0000};
        exp.hit = ref_valid[idx] && (ref_tag[idx] == tag);
        exp.rw = rw;
        wb = 1'b0;
        wb_exp = '0;
        if (!exp.hit) begin
            ref_misses++;
            // dirty victim goes back with its latest bytes
            if (ref_valid[idx] && ref_dirty[idx]) begin
                wb = 1'b1;
                wb_exp.addr = {ref_tag[idx], idx, 4'b0000};
                wb_exp.data = shadow_line(wb_exp.addr);
            end
            ref_tag[idx] = tag;
            ref_valid[idx] = 1'b1;
            ref_dirty[idx] = 1'b0;
        end
        exp.rdata = shadow_word(word_addr);
        if (rw) begin
            for (int b = 0; b < 4; b++) begin
                shadow_mem[word_addr + addr_t'(b)] = wdata[8*b +: 8];
            end
            ref_dirty[idx] = 1'b1;
        end
    endfunction

    function automatic addr_t make_addr(input int tag, input int index, input int word);
        return {tag_t'(tag), index_t'(index), 2'(word), 2'b00};
    endfunction

    // one request, held until the ready pulse
    task automatic cpu_access(input addr_t addr, input word_t wdata, input logic rw);
        expect_t exp;
        logic wb;
        wb_expect_t wb_exp;
        ref_access(addr, wdata, rw, exp, wb, wb_exp);
        exp_q.push_back(exp);
        if (wb) begin
            wb_q.push_back(wb_exp);
        end
        req_count++;
        @(posedge clk);
        #1;
        cpu_req.addr = addr;
        cpu_req.data = wdata;
        cpu_req.rw = rw;
        cpu_req.valid = 1'b1;
        do begin
            @(negedge clk);
        end while (!cpu_res.ready);
        // valid low for a cycle before the next one
        @(posedge clk);
        #1;
        cpu_req.valid = 1'b0;
    endtask

    // compares mid-cycle, where all outputs have settled
    always @(negedge clk) begin
        if (rst_n) begin
            if (mem_req.valid && !mem_req.rw) begin
                saw_fill = 1'b1;
                check_value({test_name, ": fill address"}, line_t'(exp_q[0].line_addr),
                            line_t'(mem_req.addr));
                check_value({test_name, ": busy during fill"}, line_t'(1'b1), line_t'(busy));
                check_value({test_name, ": ready during fill"}, line_t'(1'b0),
                            line_t'(cpu_res.ready));
            end
            if (mem_req.valid && mem_req.rw) begin
                check_value({test_name, ": write-back expected"}, line_t'(1'b1),
                            line_t'(wb_q.size() > 0));
                check_value({test_name, ": write-back address"}, line_t'(wb_q[0].addr),
                            line_t'(mem_req.addr));
                check_value({test_name, ": write-back data"}, wb_q[0].data, mem_req.data);
                void'(wb_q.pop_front());
            end
            if (cpu_res.ready) begin
                check_value({test_name, ": request pending"}, line_t'(1'b1),
                            line_t'(exp_q.size() > 0));
                if (!exp_q[0].rw) begin
                    check_value({test_name, ": read data"}, line_t'(exp_q[0].rdata),
                                line_t'(cpu_res.data));
                end
                check_value({test_name, ": hit"}, line_t'(exp_q[0].hit), line_t'(!saw_fill));
                check_value({test_name, ": write-backs left"}, line_t'(0),
                            line_t'(wb_q.size()));
                void'(exp_q.pop_front());
                saw_fill = 1'b0;
            end
        end
    end

    initial begin
        word_t rnd;
        word_t d;
        void'($urandom(84));
        rst_n = 1'b0;
        cpu_req = '0;
        for (int i = 0; i < NUM_SETS; i++) begin
            ref_tag[i] = '0;
            ref_valid[i] = 1'b0;
            ref_dirty[i] = 1'b0;
        end
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_value("reset: accesses", line_t'(0), line_t'(acc_count));
        check_value("reset: misses", line_t'(0), line_t'(miss_count));
        check_value("reset: busy", line_t'(1'b0), line_t'(busy));

        test_name = "cold_read";
        cpu_access(make_addr(1, 5, 2), '0, 1'b0);
        check_value("cold_read: accesses", line_t'(1), line_t'(acc_count));
        check_value("cold_read: misses", line_t'(1), line_t'(miss_count));

        // write hit, then the word and its neighbours
        test_name = "write_read";
        cpu_access(make_addr(1, 5, 1), 32'hDEAD_BEEF, 1'b1);
        cpu_access(make_addr(1, 5, 1), '0, 1'b0);
        cpu_access(make_addr(1, 5, 0), '0, 1'b0);
        cpu_access(make_addr(1, 5, 3), '0, 1'b0);

        // write miss pushes out the dirty line, read brings it back
        test_name = "dirty_evict";
        cpu_access(make_addr(2, 5, 0), 32'h1234_5678, 1'b1);
        cpu_access(make_addr(1, 5, 1), '0, 1'b0);
        cpu_access(make_addr(2, 5, 0), '0, 1'b0);

        // clean victims leave memory alone
        test_name = "clean_evict";
        cpu_access(make_addr(4, 9, 0), '0, 1'b0);
        cpu_access(make_addr(5, 9, 3), '0, 1'b0);
        cpu_access(make_addr(4, 9, 2), '0, 1'b0);

        // small pool, 4 tags x 4 sets x 4 words
        test_name = "random";
        for (int n = 0; n < NUM_RANDOM; n++) begin
            rnd = $urandom;
            d = $urandom;
            cpu_access(make_addr(int'(rnd[1:0]), int'(rnd[3:2]), int'(rnd[5:4])), d, rnd[6]);
        end

        test_name = "counters";
        check_value("counters: requests left", line_t'(0), line_t'(exp_q.size()));
        check_value("counters: accesses", line_t'(req_count), line_t'(acc_count));
        check_value("counters: misses", line_t'(ref_misses), line_t'(miss_count));
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire
